/* verilog/scroll_pkg.sv */
// ########################################
// Scroll layer constants
// Video timing, fetch offset, ROM regions
// and pixel widths for the background layer
// ########################################

package scroll_pkg;

    // Horizontal count range of one line
    localparam logic [8:0] H_START = 9'h080;
    localparam logic [8:0] H_END   = 9'h1FF;

    // Lines per frame
    localparam int V_LINES = 256;

    // Fetch runs this many pixels ahead of the display
    // Same amount delays the vertical count
    localparam int HOFFSET = 5;

    // clk cycles per 6 MHz pixel enable
    localparam int CEN_DIV = 4;
    localparam int CEN_W   = $clog2(CEN_DIV);

    // External ROM geometry
    localparam int ROM_AW = 16;
    localparam int ROM_DW = 16;

    // Top address bit picks the region
    // Clear for tile map words
    localparam logic [ROM_AW-1:0] MAP_BASE = 16'h0000;
    // Set for graphics words
    localparam logic [ROM_AW-1:0] GFX_BASE = 16'h8000;

    // Row within a 32x32 tile
    localparam int TILE_ROW_W = 5;
    // Column within a 32x32 tile, low 3 bits are the pixel
    localparam int TILE_COL_W = 5;

    // Palette output
    localparam int PXLW = 8;
    localparam logic [PXLW-1:0] BLANK_PXL = 8'hFF;

    // Palette PROM address, {bank, colour}
    localparam int PROM_AW = 8;

endpackage

/* verilog/video_timing.sv */
// ########################################
// Video timing
// 6 MHz pixel enable plus h and v counters
// ########################################

`timescale 1ns/100ps

module video_timing (
    input  logic       clk,
    input  logic       rst_n,
    output logic       cen6,
    output logic [8:0] h,
    output logic [7:0] v
);

    // Pixel enable divider
    logic [scroll_pkg::CEN_W-1:0] div_cnt;
    // Last pixel of the line
    logic                         line_end;

    assign line_end = (h == scroll_pkg::H_END);

    // Divide clk down to the pixel rate
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
            cen6    <= 1'b0;
        end else begin
            if (div_cnt == scroll_pkg::CEN_DIV - 1) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            // One clk wide, once per divider period
            cen6 <= (div_cnt == scroll_pkg::CEN_DIV - 1);
        end
    end

    // Pixel and line counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h <= scroll_pkg::H_START;
            v <= '0;
        end else if (cen6) begin
            if (line_end) begin
                // Wrap to the first visible count
                h <= scroll_pkg::H_START;
                if (v == scroll_pkg::V_LINES - 1) begin
                    v <= '0;
                end else begin
                    v <= v + 1'b1;
                end
            end else begin
                h <= h + 1'b1;
            end
        end
    end

endmodule

/* verilog/scroll_delay.sv */
// ########################################
// Pixel-rate delay line
// Shift register of any payload type
// ########################################

`timescale 1ns/100ps

module scroll_delay #(
    parameter type T      = logic [7:0],
    parameter int  STAGES = 1
) (
    input  logic clk,
    input  logic rst_n,
    input  logic cen6,
    input  T     din,
    output T     dout
);

    // Stage 0 takes the input
    T pipe [STAGES];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < STAGES; i++) begin
                pipe[i] <= '0;
            end
        end else if (cen6) begin
            pipe[0] <= din;
            // Older entries move one step down
            for (int i = 1; i < STAGES; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign dout = pipe[STAGES-1];

endmodule

/* verilog/scroll_addr.sv */
// ########################################
// Scroll address generator
// Scrolled position, flip and map requests
// ########################################

`timescale 1ns/100ps

module scroll_addr (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               cen6,
    input  logic [8:0]                         h,
    input  logic [7:0]                         v,
    input  logic [15:0]                        hpos,
    input  logic [7:0]                         vpos,
    input  logic                               flip,
    output logic                               map_req,
    output logic [scroll_pkg::ROM_AW-1:0]      map_req_addr,
    input  logic                               map_ack,
    input  logic [scroll_pkg::ROM_DW-1:0]      rom_data,
    output logic [scroll_pkg::ROM_DW-1:0]      map_word,
    output logic                               map_word_vld,
    output logic [scroll_pkg::TILE_ROW_W-1:0]  sv_row,
    output logic [scroll_pkg::TILE_COL_W-1:0]  hs
);

    logic [8:0]  h_ahead;
    logic [8:0]  h_fix;
    logic [7:0]  h_flp;
    logic        h_b7;
    logic [9:0]  h_ext;
    logic [7:0]  pic;
    logic [7:0]  sh;
    logic [7:0]  v_dly;
    logic [7:0]  v_flp;
    logic [7:0]  sv;
    logic        col_end;

    // Line count lags by the fetch offset
    scroll_delay #(
        .T      ( logic [7:0]          ),
        .STAGES ( scroll_pkg::HOFFSET  )
    ) u_vdly (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .cen6   ( cen6   ),
        .din    ( v      ),
        .dout   ( v_dly  )
    );

    // Horizontal position, HOFFSET pixels ahead
    assign h_ahead = h + 9'(scroll_pkg::HOFFSET);
    // Overflow past 0x1FF folds back above 0x080
    assign h_fix   = (!h_ahead[8] && h[8]) ? (h_ahead | 9'h080) : h_ahead;

    // Flip screen mirrors the count
    assign h_flp = {8{flip}} ^ h_fix[7:0];
    assign h_b7  = (~h_fix[8] & (~flip ^ h_flp[6])) ^ h_flp[7];
    // Signed 10-bit screen column
    assign h_ext = {h_flp[6] & ~h_fix[8], ~h_fix[8], h_b7, h_flp[6:0]};

    // Scrolled column, tile index on top
    assign {pic, sh} = hpos + {{6{h_ext[9]}}, h_ext};

    // Scrolled row
    assign v_flp = {8{flip}} ^ v_dly;
    assign sv    = vpos + v_flp;

    // Last pixel of an 8-pixel column
    assign col_end = (sh[2:0] == 3'd7);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            map_req      <= 1'b0;
            map_word_vld <= 1'b0;
        end else begin
            map_req      <= cen6 && col_end;
            map_word_vld <= map_ack;
        end
    end

    always_ff @(posedge clk) begin
        if (cen6) begin
            if (col_end) begin
                // Row and column held for the tile fetcher
                hs[4:3] <= sh[4:3];
                sv_row  <= sv[4:0];
                // Column LSB goes last so neighbours share a ROM page
                map_req_addr <= scroll_pkg::MAP_BASE |
                                {2'b00, pic, sh[7:6], sv[7:5], sh[5]};
            end
            // Pixel index in screen order
            hs[2:0] <= sh[2:0] ^ {3{flip}};
        end
        if (map_ack) begin
            map_word <= rom_data;
        end
    end

endmodule

/* verilog/tile_fetch.sv */
// ########################################
// Tile graphics fetch
// Two graphics words per tile column,
// pixel shifter and palette PROM
// ########################################

`timescale 1ns/100ps

module tile_fetch (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               cen6,
    input  logic [scroll_pkg::ROM_DW-1:0]      map_word,
    input  logic                               map_word_vld,
    input  logic [scroll_pkg::TILE_ROW_W-1:0]  sv_row,
    input  logic [scroll_pkg::TILE_COL_W-1:0]  hs,
    input  logic                               layer_on,
    input  logic                               flip,
    output logic                               gfx_req,
    output logic [scroll_pkg::ROM_AW-1:0]      gfx_req_addr,
    input  logic                               gfx_ack,
    input  logic [scroll_pkg::ROM_DW-1:0]      rom_data,
    input  logic [scroll_pkg::PROM_AW-1:0]     prog_addr,
    input  logic                               prom_we,
    input  logic [scroll_pkg::PXLW-1:0]        prom_din,
    output logic [scroll_pkg::PXLW-1:0]        pxl
);

    logic [1:0]                         gap_cnt;
    logic                               gap_run;
    logic                               half;
    logic                               mirror;
    logic [scroll_pkg::TILE_ROW_W-1:0]  row;
    logic [1:0]                         col;
    logic                               attr_adv;
    logic                               load_grp;
    // {hflip, bank} for the pixels on screen
    logic [4:0]                         attr;
    logic                               rev;
    logic [scroll_pkg::ROM_DW-1:0]      gfx_buf;
    logic [scroll_pkg::ROM_DW-1:0]      pix_sr;
    logic [3:0]                         pix;
    logic [scroll_pkg::PXLW-1:0]        prom [2**scroll_pkg::PROM_AW];

    // Half 0 right after the map word, half 1 four pixels on
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gfx_req <= 1'b0;
            gap_run <= 1'b0;
            gap_cnt <= '0;
            half    <= 1'b0;
        end else begin
            gfx_req <= 1'b0;
            if (map_word_vld) begin
                gfx_req <= 1'b1;
                half    <= 1'b0;
                gap_run <= 1'b1;
                gap_cnt <= '0;
            end else if (cen6 && gap_run) begin
                gap_cnt <= gap_cnt + 1'b1;
                if (gap_cnt == 2'd3) begin
                    gfx_req <= 1'b1;
                    half    <= 1'b1;
                    gap_run <= 1'b0;
                end
            end
        end
    end

    // Tile mirrored against the scan direction
    assign mirror = map_word[12] ^ flip;
    // vflip inverts the row, hflip the column
    assign row    = sv_row ^ {5{map_word[13]}};
    assign col    = hs[4:3] ^ {2{map_word[12]}};
    // Graphics region holds 128 tiles of 32x32
    assign gfx_req_addr = scroll_pkg::GFX_BASE |
                          {1'b0, map_word[6:0], col, row, half ^ mirror};

    // New group every 4 pixels, new tile at group 0
    assign load_grp = cen6 && (hs[1:0] == 2'b11);
    assign attr_adv = cen6 && (hs[2:0] == 3'd3);

    // Attribute waits for its first graphics word
    scroll_delay #(
        .T      ( logic [4:0]  ),
        .STAGES ( 1            )
    ) u_attr (
        .clk    ( clk            ),
        .rst_n  ( rst_n          ),
        .cen6   ( attr_adv       ),
        .din    ( map_word[12:8] ),
        .dout   ( attr           )
    );

    assign rev = attr[4] ^ flip;
    assign pix = rev ? pix_sr[3:0] : pix_sr[15:12];

    always_ff @(posedge clk) begin
        if (gfx_ack) begin
            gfx_buf <= rom_data;
        end
        if (load_grp) begin
            pix_sr <= gfx_buf;
        end else if (cen6) begin
            // shift toward the output nibble
            pix_sr <= rev ? {4'h0, pix_sr[15:4]} : {pix_sr[11:0], 4'h0};
        end
        if (prom_we) begin
            prom[prog_addr] <= prom_din;
        end
    end

    // Palette lookup at {bank, colour}
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pxl <= scroll_pkg::BLANK_PXL;
        end else if (cen6) begin
            pxl <= layer_on ? prom[{attr[3:0], pix}] : scroll_pkg::BLANK_PXL;
        end
    end

endmodule

/* verilog/rom_arbiter.sv */
// ########################################
// ROM arbiter
// Map and graphics requesters share one
// ROM, map first, one read per cycle
// ########################################

`timescale 1ns/100ps

module rom_arbiter (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           map_req,
    input  logic [scroll_pkg::ROM_AW-1:0]  map_req_addr,
    input  logic                           gfx_req,
    input  logic [scroll_pkg::ROM_AW-1:0]  gfx_req_addr,
    output logic                           rom_rd,
    output logic [scroll_pkg::ROM_AW-1:0]  rom_addr,
    output logic                           map_ack,
    output logic                           gfx_ack
);

    // One waiting request per port
    logic                           map_pend;
    logic                           gfx_pend;
    logic [scroll_pkg::ROM_AW-1:0]  map_slot;
    logic [scroll_pkg::ROM_AW-1:0]  gfx_slot;
    // Graphics read goes out this cycle
    logic                           gfx_go;

    assign gfx_go = gfx_pend && !map_pend;

    // Read straight from the slots
    assign rom_rd   = map_pend || gfx_pend;
    assign rom_addr = map_pend ? map_slot : gfx_slot;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            map_pend <= 1'b0;
            gfx_pend <= 1'b0;
            map_ack  <= 1'b0;
            gfx_ack  <= 1'b0;
        end else begin
            // Map slot always drains on the next cycle
            map_pend <= map_req;
            // Graphics slot holds while the map read goes out
            gfx_pend <= gfx_req || (gfx_pend && map_pend);
            // Owner of the read in flight, data is back next cycle
            map_ack  <= map_pend;
            gfx_ack  <= gfx_go;
        end
    end

    // Request addresses
    always_ff @(posedge clk) begin
        if (map_req) begin
            map_slot <= map_req_addr;
        end
        if (gfx_req) begin
            gfx_slot <= gfx_req_addr;
        end
    end

endmodule

/* verilog/scroll_layer.sv */
// ########################################
// Scroll background layer
// Timing, map and tile fetch sharing one
// external ROM, palette output
// ########################################

`timescale 1ns/100ps

module scroll_layer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [15:0]                    hpos,
    input  logic [7:0]                     vpos,
    input  logic                           flip,
    input  logic                           layer_on,
    input  logic [scroll_pkg::PROM_AW-1:0] prog_addr,
    input  logic                           prom_we,
    input  logic [scroll_pkg::PXLW-1:0]    prom_din,
    output logic                           rom_rd,
    output logic [scroll_pkg::ROM_AW-1:0]  rom_addr,
    input  logic [scroll_pkg::ROM_DW-1:0]  rom_data,
    output logic                           cen6,
    output logic [8:0]                     h,
    output logic [7:0]                     v,
    output logic [scroll_pkg::PXLW-1:0]    pxl
);

    // Map requester
    logic                               map_req;
    logic [scroll_pkg::ROM_AW-1:0]      map_req_addr;
    logic                               map_ack;
    // Graphics requester
    logic                               gfx_req;
    logic [scroll_pkg::ROM_AW-1:0]      gfx_req_addr;
    logic                               gfx_ack;
    // Map word and tile position to the fetcher
    logic [scroll_pkg::ROM_DW-1:0]      map_word;
    logic                               map_word_vld;
    logic [scroll_pkg::TILE_ROW_W-1:0]  sv_row;
    logic [scroll_pkg::TILE_COL_W-1:0]  hs;

    video_timing u_timing (
        .clk    ( clk   ),
        .rst_n  ( rst_n ),
        .cen6   ( cen6  ),
        .h      ( h     ),
        .v      ( v     )
    );

    scroll_addr u_addr (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .cen6         ( cen6         ),
        .h            ( h            ),
        .v            ( v            ),
        .hpos         ( hpos         ),
        .vpos         ( vpos         ),
        .flip         ( flip         ),
        .map_req      ( map_req      ),
        .map_req_addr ( map_req_addr ),
        .map_ack      ( map_ack      ),
        .rom_data     ( rom_data     ),
        .map_word     ( map_word     ),
        .map_word_vld ( map_word_vld ),
        .sv_row       ( sv_row       ),
        .hs           ( hs           )
    );

    tile_fetch u_tile (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .cen6         ( cen6         ),
        .map_word     ( map_word     ),
        .map_word_vld ( map_word_vld ),
        .sv_row       ( sv_row       ),
        .hs           ( hs           ),
        .layer_on     ( layer_on     ),
        .flip         ( flip         ),
        .gfx_req      ( gfx_req      ),
        .gfx_req_addr ( gfx_req_addr ),
        .gfx_ack      ( gfx_ack      ),
        .rom_data     ( rom_data     ),
        .prog_addr    ( prog_addr    ),
        .prom_we      ( prom_we      ),
        .prom_din     ( prom_din     ),
        .pxl          ( pxl          )
    );

    rom_arbiter u_arb (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .map_req      ( map_req      ),
        .map_req_addr ( map_req_addr ),
        .gfx_req      ( gfx_req      ),
        .gfx_req_addr ( gfx_req_addr ),
        .rom_rd       ( rom_rd       ),
        .rom_addr     ( rom_addr     ),
        .map_ack      ( map_ack      ),
        .gfx_ack      ( gfx_ack      )
    );

endmodule

/* test/scroll_layer_props.sv */
// ########################################
// Scroll layer port checks
// Reset, timing, map address, ROM sharing
// and palette output
// ########################################

`timescale 1ns/100ps

module scroll_layer_props (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] hpos,
    input  logic [7:0]  vpos,
    input  logic        flip,
    input  logic        layer_on,
    input  logic [7:0]  prog_addr,
    input  logic        prom_we,
    input  logic        rom_rd,
    input  logic [15:0] rom_addr,
    input  logic        cen6,
    input  logic [8:0]  h,
    input  logic [7:0]  v,
    input  logic [7:0]  pxl
);

    int unsigned fail_cnt = 0;
    logic        rst_low_q = 1'b0;
    logic [2:0]  clk_gap;
    logic        cen_seen;
    // Line count at the last five pixel enables
    logic [7:0]  v_hist [5];
    logic        prom_loaded;
    logic        on_q;
    logic        off_q;
    logic [2:0]  gfx_wait;
    logic [15:0] pos;
    logic [7:0]  row;
    logic        map_due;
    logic [15:0] map_exp;

    // Count HOFFSET steps through the 0x080..0x1FF sequence
    function automatic logic [8:0] h_forward(input logic [8:0] hc);
        int x;
        x = int'(hc) - int'(scroll_pkg::H_START) + scroll_pkg::HOFFSET;
        return 9'(int'(scroll_pkg::H_START) + (x % 384));
    endfunction

    // Screen column, 0x100 is column 0, 0xC0..0xFF left of it
    function automatic int screen_col(input logic [8:0] hf, input logic flp);
        int c;
        if (hf >= 9'h0C0) begin
            c = int'(hf) - 256;
        end else begin
            c = int'(hf) + 128;
        end
        // Flip mirrors around the 256-pixel screen
        if (flp) begin
            c = 255 - c;
        end
        return c;
    endfunction

    assign pos     = hpos + 16'(screen_col(h_forward(h), flip));
    assign row     = vpos + (flip ? ~v_hist[4] : v_hist[4]);
    assign map_due = cen6 && (pos[2:0] == 3'd7);
    assign map_exp = {2'b00, pos[15:8], pos[7:6], row[7:5], pos[5]};

    always_ff @(posedge clk) begin
        rst_low_q <= !rst_n;
        if (!rst_n) begin
            clk_gap     <= '0;
            cen_seen    <= 1'b0;
            prom_loaded <= 1'b0;
            on_q        <= 1'b0;
            off_q       <= 1'b0;
            gfx_wait    <= '0;
            for (int i = 0; i < 5; i++) begin
                v_hist[i] <= '0;
            end
        end else begin
            clk_gap <= cen6 ? 3'd0 : clk_gap + 3'd1;
            if (cen6) begin
                cen_seen  <= 1'b1;
                on_q      <= layer_on && prom_loaded;
                off_q     <= !layer_on;
                v_hist[0] <= v;
                for (int i = 1; i < 5; i++) begin
                    v_hist[i] <= v_hist[i-1];
                end
            end
            if (prom_we && prog_addr == 8'hFF) begin
                prom_loaded <= 1'b1;
            end
            // Graphics read due within one pixel period of the map ack
            if (rom_rd && !rom_addr[15]) begin
                gfx_wait <= 3'd5;
            end else if (rom_rd && rom_addr[15]) begin
                gfx_wait <= '0;
            end else if (gfx_wait != 0) begin
                gfx_wait <= gfx_wait - 3'd1;
            end
        end
    end

    a_reset: assert property (@(posedge clk)
        rst_low_q |-> !rom_rd && pxl == scroll_pkg::BLANK_PXL)
        else begin
            fail_cnt++;
            $error("** Error reset: rom_rd=%h pxl=%h expected pxl=%h", rom_rd, pxl,
                   scroll_pkg::BLANK_PXL);
        end

    a_cen_gap: assert property (@(posedge clk) disable iff (!rst_n)
        cen_seen |-> (cen6 ? clk_gap == 3'd3 : clk_gap < 3'd3))
        else begin
            fail_cnt++;
            $error("Pixel enable did not come once every 4 clk cycles");
        end

    a_h_range: assert property (@(posedge clk) disable iff (!rst_n)
        h >= scroll_pkg::H_START)
        else begin
            fail_cnt++;
            $error("** Error h: got %h below %h", h, scroll_pkg::H_START);
        end

    a_v_step: assert property (@(posedge clk) disable iff (!rst_n)
        v == ($past(cen6 && h == scroll_pkg::H_END) ? $past(v) + 8'd1 : $past(v)))
        else begin
            fail_cnt++;
            $error("** Error v: got %h previous %h", v, $past(v));
        end

    a_map_addr: assert property (@(posedge clk) disable iff (!rst_n)
        $past(map_due, 2) |-> rom_rd && rom_addr == $past(map_exp, 2))
        else begin
            fail_cnt++;
            $error("** Error rom_addr: got %h expected %h", rom_addr, $past(map_exp, 2));
        end

    a_map_only: assert property (@(posedge clk) disable iff (!rst_n)
        rom_rd && !rom_addr[15] |-> $past(map_due, 2))
        else begin
            fail_cnt++;
            $error("Map read at %h without a map request", rom_addr);
        end

    a_gfx_follow: assert property (@(posedge clk) disable iff (!rst_n)
        gfx_wait == 3'd1 |-> rom_rd && rom_addr[15])
        else begin
            fail_cnt++;
            $error("No graphics read followed the map read in time");
        end

    a_pxl_on: assert property (@(posedge clk) disable iff (!rst_n)
        on_q |-> pxl[7:4] == 4'hA || pxl[7:4] == 4'hB)
        else begin
            fail_cnt++;
            $error("** Error pxl: got %h expected high nibble a or b", pxl);
        end

    a_pxl_off: assert property (@(posedge clk) disable iff (!rst_n)
        off_q |-> pxl == scroll_pkg::BLANK_PXL)
        else begin
            fail_cnt++;
            $error("** Error pxl: got %h expected %h", pxl, scroll_pkg::BLANK_PXL);
        end

endmodule

bind scroll_layer scroll_layer_props u_props (
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .hpos      ( hpos      ),
    .vpos      ( vpos      ),
    .flip      ( flip      ),
    .layer_on  ( layer_on  ),
    .prog_addr ( prog_addr ),
    .prom_we   ( prom_we   ),
    .rom_rd    ( rom_rd    ),
    .rom_addr  ( rom_addr  ),
    .cen6      ( cen6      ),
    .h         ( h         ),
    .v         ( v         ),
    .pxl       ( pxl       )
);

/* test/scroll_layer_tb.sv */
// ########################################
// Scroll layer testbench
// ROM model, PROM load, scroll sweep
// ########################################

`timescale 1ns/100ps

module scroll_layer_tb;

    // clk cycles allowed per line, a line takes 1536
    localparam int WAIT_LIMIT = 4000;

    logic        clk;
    logic        rst_n;
    logic [15:0] hpos;
    logic [7:0]  vpos;
    logic        flip;
    logic        layer_on;
    logic [7:0]  prog_addr;
    logic        prom_we;
    logic [7:0]  prom_din;
    logic        rom_rd;
    logic [15:0] rom_addr;
    logic [15:0] rom_data = '0;
    logic        cen6;
    logic [8:0]  h;
    logic [7:0]  v;
    logic [7:0]  pxl;

    logic [31:0] lfsr;
    // Upper ROM byte table
    logic [7:0]  rom_hi [256];
    logic        rd_q = 1'b0;
    logic [15:0] addr_q = '0;
    int          timeouts;
    int unsigned fails;
    logic [15:0] bits;

    scroll_layer dut (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .hpos      ( hpos      ),
        .vpos      ( vpos      ),
        .flip      ( flip      ),
        .layer_on  ( layer_on  ),
        .prog_addr ( prog_addr ),
        .prom_we   ( prom_we   ),
        .prom_din  ( prom_din  ),
        .rom_rd    ( rom_rd    ),
        .rom_addr  ( rom_addr  ),
        .rom_data  ( rom_data  ),
        .cen6      ( cen6      ),
        .h         ( h         ),
        .v         ( v         ),
        .pxl       ( pxl       )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output logic [15:0] r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[14:0], lfsr[0]};
        end
    endtask

    // Map words keep bank 0 or 1 plus the two flip bits
    function automatic logic [15:0] rom_word(input logic [15:0] a);
        logic [7:0] lo;
        logic [7:0] hi;
        lo = a[7:0] ^ a[15:8];
        hi = rom_hi[lo];
        if (!a[15]) begin
            hi = hi & 8'h31;
        end
        return {hi, lo};
    endfunction

    // Data is back one clk after the read
    always @(negedge clk) begin
        if (rd_q) begin
            rom_data <= rom_word(addr_q);
        end
        rd_q   <= rom_rd;
        addr_q <= rom_addr;
    end

    // Wait for n line wraps
    task automatic wait_lines(input int n);
        int cnt;
        for (int i = 0; i < n; i++) begin
            cnt = 0;
            do begin
                @(negedge clk);
                cnt++;
            end while (!(cen6 && h == scroll_pkg::H_END) && cnt <= WAIT_LIMIT);
            if (cnt > WAIT_LIMIT) begin
                timeouts++;
                $display("Timeout: no line wrap within %0d clk cycles", WAIT_LIMIT);
                return;
            end
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        hpos      = '0;
        vpos      = '0;
        flip      = 1'b0;
        layer_on  = 1'b0;
        prog_addr = '0;
        prom_we   = 1'b0;
        prom_din  = '0;
        timeouts  = 0;
        lfsr      = 32'h799e_d238;
        for (int a = 0; a < 256; a++) begin
            take_bits(8, bits);
            rom_hi[a] = bits[7:0];
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // Entry is {0xA + bank, colour}
        for (int a = 0; a < 256; a++) begin
            @(negedge clk);
            prom_we   = 1'b1;
            prog_addr = 8'(a);
            prom_din  = {4'hA + 4'(a >> 4), 4'(a)};
        end
        @(negedge clk);
        prom_we = 1'b0;
        wait_lines(1);

        // Scroll sweep with flip and layer toggles
        for (int step = 0; step < 12 && timeouts == 0; step++) begin
            take_bits(16, bits);
            hpos = bits;
            take_bits(8, bits);
            vpos     = bits[7:0];
            flip     = step[1];
            layer_on = (step % 3 != 2);
            wait_lines(2);
        end

        fails = dut.u_props.fail_cnt;
        $display("Run complete: %0d assertion failures, %0d timeouts", fails, timeouts);
        if (fails == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
verilog/scroll_pkg.sv
verilog/video_timing.sv
verilog/scroll_delay.sv
verilog/scroll_addr.sv
verilog/tile_fetch.sv
verilog/rom_arbiter.sv
verilog/scroll_layer.sv
test/scroll_layer_props.sv
test/scroll_layer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the scroll layer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module scroll_layer_tb -o sim_scroll_layer > build.log 2>&1 \
    && ./obj_dir/sim_scroll_layer > sim.log 2>&1 \
    || { echo "Build or run failed"; exit 1; }

grep -q "SIMULATION FAILED" sim.log && { echo "Test failed"; exit 1; } \
    || grep -q "SIMULATION PASSED" sim.log \
    || { echo "No result in log"; exit 1; }
echo "Test passed"
